/* logic/cpuIsaPkg.sv */
package cpuIsaPkg;

	localparam int wordBits    = 16;
	localparam int regIdxBits  = 3;
	localparam int memAddrBits = 8;

	typedef logic [wordBits-1:0]    word_t;
	typedef logic [regIdxBits-1:0]  regIdx_t;
	typedef logic [memAddrBits-1:0] memAddr_t; // low bits of a word

	localparam int numRegs   = 1 << regIdxBits;
	localparam int imemDepth = 256;
	localparam int dmemDepth = 256;

	// ----------------------------------------
	// major opcodes at instr[15:11]
	localparam logic [4:0] opAddiu = 5'b01001;
	localparam logic [4:0] opLi    = 5'b01101;
	localparam logic [4:0] opLw    = 5'b10011;
	localparam logic [4:0] opSw    = 5'b11011;
	localparam logic [4:0] opBeqz  = 5'b00100;
	localparam logic [4:0] opB     = 5'b00010;
	localparam logic [4:0] opRrr   = 5'b11100; // ADDU, SUBU
	localparam logic [4:0] opLogic = 5'b11101; // AND, OR, JR
	localparam logic [4:0] opNop   = 5'b00001;

	// ----------------------------------------
	// function fields
	localparam logic [1:0] fnAddu = 2'b01; // instr[1:0] under opRrr
	localparam logic [1:0] fnSubu = 2'b11;
	localparam logic [4:0] fnAnd  = 5'b01100; // instr[4:0] under opLogic
	localparam logic [4:0] fnOr   = 5'b01101;
	localparam logic [4:0] fnJr   = 5'b00000;

	// bubble word for reset and flushed slots
	localparam word_t nopWord = {opNop, 11'b0};

endpackage

/* logic/cpuCtrlPkg.sv */
package cpuCtrlPkg;

	// alu function carried from decode to execute
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluPassB // LI result is the immediate
	} aluOp_t;

	// ----------------------------------------
	// operand source for the execute stage
	typedef enum logic [1:0] {
		fwdNone,  // register file value from decode
		fwdExMem, // alu result one stage ahead
		fwdMemWb  // writeback value two stages ahead
	} fwdSel_t;

endpackage

/* logic/instrDecoder.sv */
module instrDecoder
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;
(
	input  word_t   instr,
	output aluOp_t  aluOp,
	output logic    immSel,
	output word_t   immValue,
	output logic    regWrite,
	output logic    memRead,
	output logic    memWrite,
	output logic    branch,
	output logic    branchAlways,
	output logic    jump,
	output logic    usesA,
	output logic    usesB,
	output regIdx_t srcA,
	output regIdx_t srcB,
	output regIdx_t destReg
);

	assign srcA = instr[10:8]; // rx
	assign srcB = instr[7:5];  // ry

	always_comb
	begin
		aluOp        = aluAdd;
		immSel       = 1'b0;
		immValue     = '0;
		regWrite     = 1'b0;
		memRead      = 1'b0;
		memWrite     = 1'b0;
		branch       = 1'b0;
		branchAlways = 1'b0;
		jump         = 1'b0;
		usesA        = 1'b0;
		usesB        = 1'b0;
		destReg      = instr[10:8];
		// NOP and unknown opcodes keep the defaults
		case (instr[15:11])
			opAddiu:
			begin
				immSel   = 1'b1;
				immValue = {{8{instr[7]}}, instr[7:0]};
				regWrite = 1'b1;
				usesA    = 1'b1;
			end
			opLi:
			begin
				aluOp    = aluPassB;
				immSel   = 1'b1;
				immValue = {8'b0, instr[7:0]}; // zero extended
				regWrite = 1'b1;
			end
			opLw:
			begin
				immSel   = 1'b1;
				immValue = {{11{instr[4]}}, instr[4:0]};
				regWrite = 1'b1;
				memRead  = 1'b1;
				usesA    = 1'b1;
				destReg  = instr[7:5]; // load lands in ry
			end
			opSw:
			begin
				immSel   = 1'b1;
				immValue = {{11{instr[4]}}, instr[4:0]};
				memWrite = 1'b1;
				usesA    = 1'b1;
				usesB    = 1'b1; // ry is the store data
			end
			opBeqz:
			begin
				immValue = {{8{instr[7]}}, instr[7:0]};
				branch   = 1'b1;
				usesA    = 1'b1;
			end
			opB:
			begin
				immValue     = {{5{instr[10]}}, instr[10:0]};
				branch       = 1'b1;
				branchAlways = 1'b1;
			end
			opRrr:
			begin
				destReg  = instr[4:2]; // rz
				usesA    = 1'b1;
				usesB    = 1'b1;
				regWrite = (instr[1:0] == fnAddu) || (instr[1:0] == fnSubu);
				if (instr[1:0] == fnSubu)
					aluOp = aluSub;
			end
			opLogic:
			begin
				case (instr[4:0])
					fnAnd:
					begin
						aluOp    = aluAnd;
						regWrite = 1'b1;
						usesA    = 1'b1;
						usesB    = 1'b1;
					end
					fnOr:
					begin
						aluOp    = aluOr;
						regWrite = 1'b1;
						usesA    = 1'b1;
						usesB    = 1'b1;
					end
					fnJr:
					begin
						jump  = 1'b1;
						usesA = 1'b1; // target comes from rx
					end
					default: jump = 1'b0;
				endcase
			end
		endcase
	end

endmodule

/* logic/regFile.sv */
module regFile
	import cpuIsaPkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  regIdx_t readAddrA,
	input  regIdx_t readAddrB,
	output word_t   readDataA,
	output word_t   readDataB,
	input  logic    writeEnable,
	input  regIdx_t writeAddr,
	input  word_t   writeData
);

	word_t regs [numRegs];

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end
		else if (writeEnable)
			regs[writeAddr] <= writeData;
	end

	// write-through, decode sees the value retiring this cycle
	assign readDataA = (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

/* logic/hazardForward.sv */
module hazardForward
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;
(
	input  regIdx_t idSrcA,
	input  regIdx_t idSrcB,
	input  logic    idUsesA,
	input  logic    idUsesB,
	input  regIdx_t exSrcA,
	input  regIdx_t exSrcB,
	input  regIdx_t exDestReg,
	input  logic    exMemRead,
	input  regIdx_t memDestReg,
	input  logic    memRegWrite,
	input  regIdx_t wbDestReg,
	input  logic    wbRegWrite,
	output logic    stall,
	output fwdSel_t fwdA,
	output fwdSel_t fwdB
);

	// younger producer wins
	function automatic fwdSel_t pickSource(regIdx_t src);
		pickSource = fwdNone;
		if (memRegWrite && memDestReg == src)
			pickSource = fwdExMem;
		else if (wbRegWrite && wbDestReg == src)
			pickSource = fwdMemWb;
	endfunction

	always_comb
	begin
		fwdA = pickSource(exSrcA);
		fwdB = pickSource(exSrcB);
	end

	// load data only exists after MEM, so the consumer waits one cycle
	assign stall = exMemRead &&
		((idUsesA && idSrcA == exDestReg) || (idUsesB && idSrcB == exDestReg));

endmodule

/* logic/executeStage.sv */
module executeStage
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;
(
	input  word_t   pc,
	input  word_t   regA,
	input  word_t   regB,
	input  word_t   immValue,
	input  logic    immSel,
	input  aluOp_t  aluOp,
	input  fwdSel_t fwdA,
	input  fwdSel_t fwdB,
	input  word_t   memAluResult,
	input  word_t   wbData,
	output word_t   aluResult,
	output word_t   storeData,
	output word_t   branchTarget,
	output word_t   jumpTarget,
	output logic    zero
);

	word_t opA;
	word_t regBFwd;
	word_t opB;

	function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t exMem, word_t memWb);
		case (sel)
			fwdExMem: fwdMux = exMem;
			fwdMemWb: fwdMux = memWb;
			default:  fwdMux = regVal;
		endcase
	endfunction

	assign opA     = fwdMux(fwdA, regA, memAluResult, wbData);
	assign regBFwd = fwdMux(fwdB, regB, memAluResult, wbData);
	assign opB     = immSel ? immValue : regBFwd;

	always_comb
	begin
		case (aluOp)
			aluSub:   aluResult = opA - opB;
			aluAnd:   aluResult = opA & opB;
			aluOr:    aluResult = opA | opB;
			aluPassB: aluResult = opB;
			default:  aluResult = opA + opB;
		endcase
	end

	assign storeData    = regBFwd; // SW writes ry
	assign zero         = (opA == '0); // BEQZ tests rx
	assign branchTarget = pc + word_t'(1) + immValue;
	assign jumpTarget   = opA;

endmodule

/* logic/dataMemory.sv */
module dataMemory #(
	parameter int dataBits = 16,
	parameter int addrBits = 8,
	parameter int depth    = 256
) (
	input  logic                CLK,
	input  logic                memWrite,
	input  logic [addrBits-1:0] address,
	input  logic [dataBits-1:0] writeData,
	output logic [dataBits-1:0] readData
);

	logic [dataBits-1:0] mem [depth];

	always_ff @(posedge CLK)
	begin
		if (memWrite)
			mem[address] <= writeData;
	end

	assign readData = mem[address]; // asynchronous read

endmodule

/* logic/pipelineCpu.sv */
module pipelineCpu
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  logic     progWrite,
	input  memAddr_t progAddr,
	input  word_t    progData,
	output logic     wbValid,
	output regIdx_t  wbReg,
	output word_t    wbData
);

	word_t   imem [imemDepth];
	word_t   pc;
	word_t   nextPc;
	word_t   fetchInstr;
	logic    stall;
	logic    jumpTaken;
	logic    branchTaken;
	logic    idKill;

	word_t   ifIdPc;
	word_t   ifIdInstr;

	aluOp_t  idAluOp;
	logic    idImmSel;
	word_t   idImm;
	logic    idRegWrite, idMemRead, idMemWrite;
	logic    idBranch, idBranchAlways, idJump;
	logic    idUsesA, idUsesB;
	regIdx_t idSrcA, idSrcB, idDestReg;
	word_t   idRegA, idRegB;

	word_t   exPc, exRegA, exRegB, exImm;
	logic    exImmSel;
	aluOp_t  exAluOp;
	regIdx_t exSrcA, exSrcB, exDestReg;
	logic    exRegWrite, exMemRead, exMemWrite;
	logic    exBranch, exBranchAlways, exJump;
	fwdSel_t fwdA, fwdB;
	word_t   exAluResult, exStoreData, exBranchTarget, exJumpTarget;
	logic    exZero;

	word_t   memAluResult, memStoreData, memBranchTarget, memReadData;
	logic    memZero;
	regIdx_t memDestReg;
	logic    memRegWrite, memMemRead, memMemWrite, memBranch, memBranchAlways;

	word_t   wbAluResult, wbMemData;
	logic    wbMemToReg, wbRegWrite;
	regIdx_t wbDestReg;

	// ----------------------------------------
	// fetch
	always_ff @(posedge CLK)
	begin
		if (progWrite)
			imem[progAddr] <= progData;
	end

	assign fetchInstr = imem[memAddr_t'(pc)];

	assign branchTaken = memBranch && (memZero || memBranchAlways);
	assign jumpTaken   = exJump && !branchTaken; // an older branch flushes the JR

	always_comb
	begin
		if (stall)
			nextPc = pc;
		else if (jumpTaken)
			nextPc = exJumpTarget;
		else if (branchTaken)
			nextPc = memBranchTarget;
		else
			nextPc = pc + word_t'(1);
	end

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			pc <= '0;
		else
			pc <= nextPc;
	end

	// IF/ID
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			ifIdInstr <= nopWord;
		else if (jumpTaken || branchTaken)
			ifIdInstr <= nopWord;
		else if (!stall)
			ifIdInstr <= fetchInstr;
	end

	always_ff @(posedge CLK)
	begin
		if (!stall)
			ifIdPc <= pc;
	end

	// ----------------------------------------
	// decode
	instrDecoder i_instrDecoder (
		.instr(ifIdInstr), .aluOp(idAluOp), .immSel(idImmSel), .immValue(idImm),
		.regWrite(idRegWrite), .memRead(idMemRead), .memWrite(idMemWrite),
		.branch(idBranch), .branchAlways(idBranchAlways), .jump(idJump),
		.usesA(idUsesA), .usesB(idUsesB),
		.srcA(idSrcA), .srcB(idSrcB), .destReg(idDestReg)
	);

	regFile i_regFile (
		.CLK(CLK), .RST(RST),
		.readAddrA(idSrcA), .readAddrB(idSrcB),
		.readDataA(idRegA), .readDataB(idRegB),
		.writeEnable(wbRegWrite), .writeAddr(wbDestReg), .writeData(wbData)
	);

	hazardForward i_hazardForward (
		.idSrcA(idSrcA), .idSrcB(idSrcB), .idUsesA(idUsesA), .idUsesB(idUsesB),
		.exSrcA(exSrcA), .exSrcB(exSrcB), .exDestReg(exDestReg),
		.exMemRead(exMemRead && !branchTaken), // a load being flushed never stalls
		.memDestReg(memDestReg), .memRegWrite(memRegWrite),
		.wbDestReg(wbDestReg), .wbRegWrite(wbRegWrite),
		.stall(stall), .fwdA(fwdA), .fwdB(fwdB)
	);

	// bubble on load-use and on either flush
	assign idKill = stall || jumpTaken || branchTaken;

	// ID/EX
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			exRegWrite <= 1'b0;
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exBranch   <= 1'b0;
			exJump     <= 1'b0;
		end
		else
		begin
			exRegWrite <= idRegWrite && !idKill;
			exMemRead  <= idMemRead && !idKill;
			exMemWrite <= idMemWrite && !idKill;
			exBranch   <= idBranch && !idKill;
			exJump     <= idJump && !idKill;
		end
	end

	always_ff @(posedge CLK)
	begin
		exPc           <= ifIdPc;
		exRegA         <= idRegA;
		exRegB         <= idRegB;
		exImm          <= idImm;
		exImmSel       <= idImmSel;
		exAluOp        <= idAluOp;
		exSrcA         <= idSrcA;
		exSrcB         <= idSrcB;
		exDestReg      <= idDestReg;
		exBranchAlways <= idBranchAlways;
	end

	// ----------------------------------------
	// execute
	executeStage i_executeStage (
		.pc(exPc), .regA(exRegA), .regB(exRegB), .immValue(exImm), .immSel(exImmSel),
		.aluOp(exAluOp), .fwdA(fwdA), .fwdB(fwdB),
		.memAluResult(memAluResult), .wbData(wbData),
		.aluResult(exAluResult), .storeData(exStoreData),
		.branchTarget(exBranchTarget), .jumpTarget(exJumpTarget), .zero(exZero)
	);

	// EX/MEM
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			memRegWrite <= 1'b0;
			memMemRead  <= 1'b0;
			memMemWrite <= 1'b0;
			memBranch   <= 1'b0;
		end
		else
		begin
			memRegWrite <= exRegWrite && !branchTaken;
			memMemRead  <= exMemRead && !branchTaken;
			memMemWrite <= exMemWrite && !branchTaken;
			memBranch   <= exBranch && !branchTaken;
		end
	end

	always_ff @(posedge CLK)
	begin
		memAluResult    <= exAluResult;
		memStoreData    <= exStoreData;
		memZero         <= exZero;
		memBranchTarget <= exBranchTarget;
		memDestReg      <= exDestReg;
		memBranchAlways <= exBranchAlways;
	end

	// ----------------------------------------
	// memory and writeback
	dataMemory #(
		.dataBits(wordBits), .addrBits(memAddrBits), .depth(dmemDepth)
	) i_dataMemory (
		.CLK(CLK), .memWrite(memMemWrite), .address(memAddr_t'(memAluResult)),
		.writeData(memStoreData), .readData(memReadData)
	);

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			wbRegWrite <= 1'b0;
		else
			wbRegWrite <= memRegWrite;
	end

	always_ff @(posedge CLK)
	begin
		wbAluResult <= memAluResult;
		wbMemData   <= memReadData;
		wbMemToReg  <= memMemRead;
		wbDestReg   <= memDestReg;
	end

	assign wbData  = wbMemToReg ? wbMemData : wbAluResult;
	assign wbValid = wbRegWrite; // one pulse per retiring register write
	assign wbReg   = wbDestReg;

endmodule

/* tests/pipelineCpu_props.sv */
module pipelineCpuProps
	import cpuIsaPkg::*;
(
	input logic  CLK,
	input logic  RST,
	input logic  stall,
	input word_t pc,
	input logic  jumpTaken,
	input logic  branchTaken,
	input logic  wbValid
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0; // read by the testbench at the end

	// fetch address frozen under a load-use bubble
	assert property (@(posedge CLK) disable iff (!RST) stall |=> pc == $past(pc))
	else
	begin
		$error("PC moved during a load-use stall");
		failures++;
	end

	assert property (@(posedge CLK) disable iff (!RST) !$isunknown(wbValid))
	else
	begin
		$error("wbValid is unknown");
		failures++;
	end

	// ----------------------------------------
	// branch slot itself plus three flushed slots retire nothing
	assert property (@(posedge CLK) disable iff (!RST)
		($past(branchTaken, 1) || $past(branchTaken, 2) || $past(branchTaken, 3)
			|| $past(branchTaken, 4)) |-> !wbValid)
	else
	begin
		$error("a slot flushed by a taken branch reached writeback");
		failures++;
	end

	// JR plus its two flushed slots
	assert property (@(posedge CLK) disable iff (!RST)
		($past(jumpTaken, 2) || $past(jumpTaken, 3) || $past(jumpTaken, 4)) |-> !wbValid)
	else
	begin
		$error("a slot flushed by a taken JR reached writeback");
		failures++;
	end

endmodule

bind pipelineCpu pipelineCpuProps i_pipelineCpuProps (
	.CLK(CLK), .RST(RST), .stall(stall), .pc(pc),
	.jumpTaken(jumpTaken), .branchTaken(branchTaken), .wbValid(wbValid)
);

/* tests/pipelineCpuTb.sv */
module pipelineCpuTb
	import cpuIsaPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int numTests    = 5;
	localparam int maxWords    = 16;
	localparam int resetCycles = 16;
	localparam int quietCycles = 20; // no writeback allowed once a trace is complete
	localparam int eventLimit  = 30; // cycles allowed between two trace events

	logic     CLK;
	logic     RST;
	logic     progWrite;
	memAddr_t progAddr;
	word_t    progData;
	logic     wbValid;
	regIdx_t  wbReg;
	word_t    wbData;

	// test table, one row per program
	string   testName  [numTests];
	word_t   progWords [numTests][maxWords];
	int      progLen   [numTests];
	regIdx_t expReg    [numTests][maxWords];
	word_t   expData   [numTests][maxWords];
	int      expLen    [numTests];
	int      row;
	logic    tableReady;

	pipelineCpu i_pipelineCpu (
		.CLK(CLK), .RST(RST),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// ----------------------------------------
	// instruction assembly
	function automatic word_t liInstr(regIdx_t rx, logic [7:0] imm);
		return {opLi, rx, imm};
	endfunction

	function automatic word_t addiuInstr(regIdx_t rx, logic [7:0] imm);
		return {opAddiu, rx, imm};
	endfunction

	function automatic word_t rrrInstr(regIdx_t rx, regIdx_t ry, regIdx_t rz, logic [1:0] fn);
		return {opRrr, rx, ry, rz, fn}; // rz = rx op ry
	endfunction

	function automatic word_t logicInstr(regIdx_t rx, regIdx_t ry, logic [4:0] fn);
		return {opLogic, rx, ry, fn};
	endfunction

	function automatic word_t memInstr(logic [4:0] op, regIdx_t rx, regIdx_t ry, logic [4:0] ofs);
		return {op, rx, ry, ofs};
	endfunction

	function automatic word_t beqzInstr(regIdx_t rx, logic [7:0] ofs);
		return {opBeqz, rx, ofs};
	endfunction

	function automatic word_t bInstr(logic [10:0] ofs);
		return {opB, ofs};
	endfunction

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ----------------------------------------
	// table building
	task automatic startRow(string name);
		row++;
		testName[row] = name;
		progLen[row]  = 0;
		expLen[row]   = 0;
		for (int i = 0; i < maxWords; i++)
			progWords[row][i] = nopWord;
	endtask

	task automatic addWord(word_t w);
		progWords[row][progLen[row]] = w;
		progLen[row]++;
	endtask

	task automatic expectWrite(regIdx_t r, word_t v);
		expReg[row][expLen[row]]  = r;
		expData[row][expLen[row]] = v;
		expLen[row]++;
	endtask

	task automatic buildTable();
		logic [31:0] rng;
		word_t       rnd [4];
		word_t       sum;
		word_t       diff;
		word_t       acc;
		word_t       back;
		row = -1;

		startRow("aluChain"); // every op consumes the result just before it
		addWord(liInstr(1, 8'h35));          expectWrite(1, 16'h0035);
		addWord(liInstr(2, 8'h0F));          expectWrite(2, 16'h000F);
		addWord(rrrInstr(1, 2, 3, fnAddu));  expectWrite(3, 16'h0044);
		addWord(rrrInstr(3, 1, 4, fnSubu));  expectWrite(4, 16'h000F);
		addWord(logicInstr(4, 3, fnAnd));    expectWrite(4, 16'h0004);
		addWord(logicInstr(4, 1, fnOr));     expectWrite(4, 16'h0035);
		addWord(addiuInstr(4, 8'hF0));       expectWrite(4, 16'h0025); // minus 16
		addWord(rrrInstr(0, 4, 5, fnSubu));  expectWrite(5, 16'hFFDB);
		addWord(bInstr(11'h7FF));

		startRow("loadStore");
		addWord(liInstr(1, 8'h20));               expectWrite(1, 16'h0020);
		addWord(liInstr(2, 8'hA5));               expectWrite(2, 16'h00A5);
		addWord(memInstr(opSw, 1, 2, 5'd3));      // mem[0x23] = r2
		addWord(memInstr(opLw, 1, 3, 5'd3));      expectWrite(3, 16'h00A5);
		addWord(rrrInstr(3, 2, 4, fnAddu));       expectWrite(4, 16'h014A); // load-use
		addWord(addiuInstr(1, 8'h05));            expectWrite(1, 16'h0025);
		addWord(memInstr(opLw, 1, 6, 5'h1E));     expectWrite(6, 16'h00A5); // offset -2
		addWord(logicInstr(6, 4, fnOr));          expectWrite(6, 16'h01EF);
		addWord(bInstr(11'h7FF));

		startRow("branches");
		addWord(liInstr(1, 8'h07));       expectWrite(1, 16'h0007);
		addWord(beqzInstr(0, 8'h03));     // taken, lands on 5
		addWord(liInstr(2, 8'h11));
		addWord(liInstr(3, 8'h22));
		addWord(liInstr(4, 8'h33));
		addWord(addiuInstr(1, 8'h01));    expectWrite(1, 16'h0008);
		addWord(beqzInstr(1, 8'h04));     // not taken
		addWord(liInstr(5, 8'h44));       expectWrite(5, 16'h0044);
		addWord(bInstr(11'h001));         // skips one slot
		addWord(liInstr(6, 8'h55));
		addWord(bInstr(11'h7FF));

		startRow("jumpRegister");
		addWord(liInstr(1, 8'h06));           expectWrite(1, 16'h0006);
		addWord(logicInstr(1, 0, fnJr));
		addWord(liInstr(2, 8'h11));
		addWord(liInstr(3, 8'h22));
		addWord(liInstr(4, 8'h33));
		addWord(liInstr(5, 8'h44));
		addWord(liInstr(6, 8'h66));           expectWrite(6, 16'h0066);
		addWord(rrrInstr(6, 1, 7, fnAddu));   expectWrite(7, 16'h006C);
		addWord(bInstr(11'h7FF));

		rng = 32'haf5;
		for (int i = 0; i < 4; i++)
		begin
			rng    = xorshift(rng);
			rnd[i] = {8'h00, rng[7:0]};
		end
		sum  = rnd[0] + rnd[1];
		diff = rnd[2] - sum;
		acc  = diff + rnd[3];
		back = acc - rnd[0];
		startRow("random");
		addWord(liInstr(1, rnd[0][7:0]));    expectWrite(1, rnd[0]);
		addWord(liInstr(2, rnd[1][7:0]));    expectWrite(2, rnd[1]);
		addWord(liInstr(3, rnd[2][7:0]));    expectWrite(3, rnd[2]);
		addWord(rrrInstr(1, 2, 4, fnAddu));  expectWrite(4, sum);
		addWord(rrrInstr(3, 4, 5, fnSubu));  expectWrite(5, diff);
		addWord(liInstr(6, rnd[3][7:0]));    expectWrite(6, rnd[3]);
		addWord(rrrInstr(5, 6, 7, fnAddu));  expectWrite(7, acc);
		addWord(rrrInstr(7, 1, 1, fnSubu));  expectWrite(1, back);
		addWord(rrrInstr(1, 1, 2, fnAddu));  expectWrite(2, back + back);
		addWord(bInstr(11'h7FF));
	endtask

	// ----------------------------------------
	// checking
	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(string name, string what, word_t expected, word_t actual);
		if (expected !== actual)
			abortRun($sformatf("Error: test %s, %s expected %h, actual %h",
				name, what, expected, actual));
	endtask

	task automatic runTest(int t);
		int seen;
		int idle;
		@(negedge CLK);
		RST = 1'b0;
		for (int i = 0; i < resetCycles; i++)
		begin
			progWrite = (i < progLen[t]); // one word per cycle while in reset
			progAddr  = memAddr_t'(i);
			progData  = progWords[t][i];
			@(negedge CLK);
		end
		progWrite = 1'b0;
		RST       = 1'b1;

		seen = 0;
		idle = 0;
		while (seen < expLen[t])
		begin
			@(negedge CLK);
			if (wbValid)
			begin
				checkValue(testName[t], "register", word_t'(expReg[t][seen]), word_t'(wbReg));
				checkValue(testName[t], "data", expData[t][seen], wbData);
				seen++;
				idle = 0;
			end
			else
			begin
				idle++;
				if (idle > eventLimit)
					abortRun($sformatf("test %s got no writeback within %0d cycles, %0d of %0d seen",
						testName[t], eventLimit, seen, expLen[t]));
			end
		end

		repeat (quietCycles)
		begin
			@(negedge CLK);
			if (wbValid)
				abortRun($sformatf("test %s wrote r%0d = %h after its last expected writeback",
					testName[t], wbReg, wbData));
		end
		$display("test %s: %0d writebacks matched", testName[t], expLen[t]);
	endtask

	// ----------------------------------------
	initial
	begin : watchdog
		int limitCycles;
		wait (tableReady === 1'b1);
		limitCycles = 0;
		for (int t = 0; t < numTests; t++)
			limitCycles += (progLen[t] + quietCycles) * 8;
		#(limitCycles * 10);
		abortRun($sformatf("watchdog expired after %0d cycles, the run never finished", limitCycles));
	end

	initial
	begin
		RST        = 1'b0;
		progWrite  = 1'b0;
		progAddr   = '0;
		progData   = '0;
		tableReady = 1'b0;
		buildTable();
		tableReady = 1'b1;
		for (int t = 0; t < numTests; t++)
			runTest(t);
		if (i_pipelineCpu.i_pipelineCpuProps.failures == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
			abortRun($sformatf("%0d pipeline assertions failed",
				i_pipelineCpu.i_pipelineCpuProps.failures));
	end

endmodule

/* list.f */
logic/cpuIsaPkg.sv
logic/cpuCtrlPkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/hazardForward.sv
logic/executeStage.sv
logic/dataMemory.sv
logic/pipelineCpu.sv
tests/pipelineCpu_props.sv
tests/pipelineCpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the pipelined CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module pipelineCpuTb --Mdir "$buildDir" -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$buildDir/simv" +verilator+error+limit+100 > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: PASS" "$logFile"; then
	exit 0
fi
echo "pass message not found in $logFile"
exit 1
